//--- verif/lane_input.txt
// instruction word   expected commit data   (hex)
// registers start at zero, w = window, r = register number
A0891A00 00001234 // MOVI w0 r1 0x1234
A17FF800 FFFFFFF0 // MOVI w0 r2 -16
01890000 00001224 // ADD w0 r3 r1 r2
22188000 FFFFFFF0 // SUB w0 r4 r3 r1
42898000 00001224 // AND w0 r5 r1 r3
63208000 FFFFFFF4 // OR w0 r6 r4 r1
83B28000 FFFFEDD0 // XOR w0 r7 r6 r5
A8803B80 00000077 // MOVI w1 r1 0x77
09088000 000000EE // ADD w1 r2 r1 r1
04090000 00001224 // ADD w0 r8 r1 r2
29920000 000000EE // SUB w1 r3 r2 r4
BFC00000 FFFF8000 // MOVI w3 r15 0x8000
9F780000 FFFF8000 // XOR w3 r14 r15 r0
5EF78000 FFFF8000 // AND w3 r13 r14 r15
// dependent chain, written while commit grant is held low
B0800080 00000001 // MOVI w2 r1 1
10888000 00000002 // ADD w2 r1 r1 r1
10888000 00000004 // ADD w2 r1 r1 r1
11088000 00000008 // ADD w2 r2 r1 r1
31908000 00000004 // SUB w2 r3 r2 r1
72190000 0000000C // OR w2 r4 r3 r2
92208000 00000008 // XOR w2 r4 r4 r1
12A18000 0000000C // ADD w2 r5 r4 r3
B33FFF80 00007FFF // MOVI w2 r6 0x7FFF
13330000 0000FFFE // ADD w2 r6 r6 r6
33AB0000 FFFF000E // SUB w2 r7 r5 r6
543B0000 0000000E // AND w2 r8 r7 r6
04B98000 FFFFFFF4 // ADD w0 r9 r7 r3
B0D5E680 FFFFABCD // MOVI w2 r1 0xABCD
948C0000 FFFFABC3 // XOR w2 r9 r1 r8
354C8000 00000000 // SUB w2 r10 r9 r9

//--- files.f
rtl/lane_pkg.sv
rtl/reg_bank.sv
rtl/cmd_intake.sv
rtl/index_stage.sv
rtl/operand_read.sv
rtl/exec_unit.sv
rtl/commit_queue.sv
rtl/lane_top.sv
verif/lane_chk.sv
verif/lane_monitor.sv
verif/lane_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module lane_tb -f files.f -o lane_sim
./obj_dir/lane_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
	echo "Run passed"
else
	echo "Run failed"
	exit 1
fi

//--- verif/lane_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lane_tb;

	localparam int MAX_LINES = 64;
	localparam int FIRST_PART = 14;	// Lines written before back-pressure
	localparam int ACK_LIMIT = 200;
	localparam int STALL_LIMIT = 16;
	localparam int COMMIT_LIMIT = 2000;

	logic clock;
	logic reset;
	lane_pkg::wb_req_t wb_req;
	lane_pkg::wb_rsp_t wb_rsp;
	lane_pkg::result_t commit;
	logic commit_req;
	logic commit_grant;
	logic hold_grant;
	logic [31:0] lcg_state;
	logic [31:0] stim [2*MAX_LINES];	// Instruction, expected data
	int num_lines;
	int bus_errors;
	int commit_count;
	int commit_errors;
	bit timed_out;

	lane_top UUT (
		.clock(clock),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.commit(commit),
		.commit_req(commit_req),
		.commit_grant(commit_grant)
	);

	lane_monitor #(
		.MAX_LINES(MAX_LINES)
	) monitor (
		.clock(clock),
		.reset(reset),
		.commit(commit),
		.commit_req(commit_req),
		.commit_grant(commit_grant),
		.commit_count(commit_count),
		.error_count(commit_errors)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	initial begin
		lcg_state = 32'h2a06;
		commit_grant = 1'b0;
		forever begin
			@(posedge clock);
			#1;
			lcg_state = lcg_next(lcg_state);
			commit_grant = ~hold_grant & lcg_state[16];
		end
	end

	////////////////////
	// Wishbone master

	// Stb stays up through the edge that samples ack
	task automatic bus_cycle(input logic we, input logic [31:0] data, input int limit,
			output bit acked, output logic [31:0] rdata);
		acked = 1'b0;
		rdata = '0;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, dat: data};
		for (int i = 0; i < limit && !acked; i++) begin
			@(posedge clock);
			#1;
			if (wb_rsp.ack) begin
				acked = 1'b1;
				rdata = wb_rsp.dat;
			end
		end
		if (acked) begin
			@(posedge clock);
			#1;
		end
		wb_req = '0;
	endtask

	task automatic check_read(input int expected);
		bit acked;
		logic [31:0] rdata;
		bus_cycle(1'b0, 32'h0, ACK_LIMIT, acked, rdata);
		if (!acked) begin
			$display("Timeout: a read cycle was never acked");
			bus_errors++;
			timed_out = 1'b1;
		end else if (rdata != 32'(expected)) begin
			$display("[FAIL] wb_rsp.dat: got %h, expected %h", rdata, 32'(expected));
			bus_errors++;
		end
	endtask

	task automatic send_all();
		bit acked;
		bit stalled;
		logic [31:0] rdata;
		stalled = 1'b0;
		for (int i = 0; i < num_lines; i++) begin
			if (i == FIRST_PART) begin
				check_read(i);
				hold_grant = 1'b1;	// Queue and ring buffer fill up
			end
			bus_cycle(1'b1, stim[2*i], hold_grant ? STALL_LIMIT : ACK_LIMIT, acked, rdata);
			if (!acked && hold_grant) begin
				stalled = 1'b1;
				check_read(i);	// Stalled write not counted yet
				hold_grant = 1'b0;
				bus_cycle(1'b1, stim[2*i], ACK_LIMIT, acked, rdata);
			end
			if (!acked) begin
				$display("Timeout: write %0d was never acked", i);
				bus_errors++;
				timed_out = 1'b1;
				return;
			end
		end
		hold_grant = 1'b0;
		if (!stalled) begin
			$display("Ack was never withheld while commit grant was held low");
			bus_errors++;
		end
	endtask

	task automatic wait_commits();
		int cycles;
		cycles = 0;
		while (commit_count < num_lines && cycles < COMMIT_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		if (commit_count < num_lines) begin
			$display("Timeout: only %0d of %0d instructions committed", commit_count, num_lines);
			timed_out = 1'b1;
		end
	endtask

	initial begin
		reset = 1'b1;
		wb_req = '0;
		hold_grant = 1'b0;
		bus_errors = 0;
		timed_out = 1'b0;
		for (int i = 0; i < 2 * MAX_LINES; i++) begin
			stim[i] = '1;
		end
		$readmemh("verif/lane_input.txt", stim);
		num_lines = 0;
		while (num_lines < MAX_LINES && stim[2*num_lines] != '1) begin
			num_lines++;
		end
		if (num_lines == 0) begin
			$display("No stimulus lines were read from the data file");
			bus_errors++;
		end
		repeat (3) @(posedge clock);
		#1;
		reset = 1'b0;
		check_read(0);
		send_all();
		if (!timed_out) begin
			wait_commits();
		end
		if (!timed_out) begin
			check_read(num_lines);
		end
		$display("Commits %0d of %0d, commit errors %0d, bus errors %0d",
			commit_count, num_lines, commit_errors, bus_errors);
		if (timed_out || bus_errors != 0 || commit_errors != 0) begin
			$display("Simulation finished: FAIL");
		end else begin
			$display("Simulation finished: PASS");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/lane_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module lane_monitor #(
	parameter int MAX_LINES = 64
) (
	input wire logic clock,
	input wire logic reset,
	input wire lane_pkg::result_t commit,
	input wire logic commit_req,
	input wire logic commit_grant,
	output int commit_count,
	output int error_count
);

	logic [31:0] stim [2*MAX_LINES];

	initial begin
		for (int i = 0; i < 2 * MAX_LINES; i++) begin
			stim[i] = '1;
		end
		$readmemh("verif/lane_input.txt", stim);
	end

	////////////////////
	// Commit compare

	// Req and grant are settled at the falling edge, transfer follows at the rising one
	always @(negedge clock) begin
		int errs;
		lane_pkg::phys_idx_t exp_dst;
		errs = 0;
		if (reset) begin
			commit_count <= 0;
			error_count <= 0;
		end else if (commit_req && commit_grant) begin
			if (!commit.valid) begin
				$display("[FAIL] commit.valid: got %h, expected %h", commit.valid, 1'b1);
				errs++;
			end
			if (commit_count >= MAX_LINES || stim[2*commit_count] == '1) begin
				$display("Commit with issue number %0d has no stimulus line", commit.issue_no);
				errs++;
			end else begin
				// Window bits above the destination register number
				exp_dst = {stim[2*commit_count][28:27], stim[2*commit_count][26:23]};
				if (commit.issue_no != lane_pkg::issue_no_t'(commit_count)) begin
					$display("[FAIL] commit.issue_no: got %h, expected %h",
						commit.issue_no, lane_pkg::issue_no_t'(commit_count));
					errs++;
				end
				if (commit.dst != exp_dst) begin
					$display("[FAIL] commit.dst: got %h, expected %h (line %0d)",
						commit.dst, exp_dst, commit_count);
					errs++;
				end
				if (commit.data != stim[2*commit_count+1]) begin
					$display("[FAIL] commit.data: got %h, expected %h (line %0d)",
						commit.data, stim[2*commit_count+1], commit_count);
					errs++;
				end
			end
			commit_count <= commit_count + 1;
			error_count <= error_count + errs;
		end
	end

endmodule

`default_nettype wire

//--- verif/lane_chk.sv
`timescale 1ns/1ps
`default_nettype none

module lane_chk (
	input wire logic clock,
	input wire logic reset,
	input wire lane_pkg::wb_req_t wb_req,
	input wire lane_pkg::wb_rsp_t wb_rsp,
	input wire lane_pkg::result_t commit,
	input wire logic commit_req,
	input wire logic commit_grant
);

	ack_in_cycle: assert property (@(posedge clock) disable iff (reset)
		wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
		else $error("ack outside an active strobe");

	ack_single: assert property (@(posedge clock) disable iff (reset)
		wb_rsp.ack |=> !wb_rsp.ack)
		else $error("ack high on two cycles in a row");

	// Head may not move while the grant is missing
	commit_hold: assert property (@(posedge clock) disable iff (reset)
		commit_req && !commit_grant |=> commit_req && $stable(commit))
		else $error("commit head changed without a grant");

endmodule

bind lane_top lane_chk chk (
	.clock(clock),
	.reset(reset),
	.wb_req(wb_req),
	.wb_rsp(wb_rsp),
	.commit(commit),
	.commit_req(commit_req),
	.commit_grant(commit_grant)
);

`default_nettype wire

//--- rtl/lane_top.sv
`timescale 1ns/1ps
`default_nettype none

module lane_top #(
	parameter int BUFF_DEPTH = 4,
	parameter int COMMIT_DEPTH = 8
) (
	input wire logic clock,
	input wire logic reset,
	input wire lane_pkg::wb_req_t wb_req,
	output lane_pkg::wb_rsp_t wb_rsp,
	output lane_pkg::result_t commit,
	output logic commit_req,
	input wire logic commit_grant
);

	lane_pkg::issue_t issue;
	lane_pkg::decoded_t decoded;
	lane_pkg::operand_t operand;
	lane_pkg::result_t result;	// Write-back value
	logic credit;

	cmd_intake #(
		.BUFF_DEPTH(BUFF_DEPTH)
	) intake (
		.clock(clock),
		.reset(reset),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.credit(credit),
		.issue(issue)
	);

	index_stage index (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.decoded(decoded)
	);

	operand_read read (
		.clock(clock),
		.reset(reset),
		.decoded(decoded),
		.wb(result),
		.operand(operand)
	);

	exec_unit exec (
		.clock(clock),
		.reset(reset),
		.operand(operand),
		.result(result)
	);

	commit_queue #(
		.COMMIT_DEPTH(COMMIT_DEPTH)
	) queue (
		.clock(clock),
		.reset(reset),
		.wb(result),
		.commit(commit),
		.commit_req(commit_req),
		.commit_grant(commit_grant),
		.credit(credit)
	);

endmodule

`default_nettype wire

//--- rtl/commit_queue.sv
`timescale 1ns/1ps
`default_nettype none

module commit_queue #(
	parameter int COMMIT_DEPTH = 8
) (
	input wire logic clock,
	input wire logic reset,
	input wire lane_pkg::result_t wb,
	output lane_pkg::result_t commit,
	output logic commit_req,
	input wire logic commit_grant,
	output logic credit
);

	localparam int PTR_W = (COMMIT_DEPTH > 1) ? $clog2(COMMIT_DEPTH) : 1;
	localparam int CNT_W = $clog2(COMMIT_DEPTH + 1);

	lane_pkg::result_t fifo [COMMIT_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic push;
	logic pop;

	assign push = wb.valid;
	assign pop = commit_req & commit_grant;	// Head retires

	always_ff @(posedge clock) begin
		if (push) begin
			fifo[wr_ptr] <= wb;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(COMMIT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(COMMIT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	////////////////////
	// Head and credit

	assign commit_req = count != '0;

	always_comb begin
		commit = fifo[rd_ptr];
		commit.valid = commit_req;
	end

	// Room left for everything already in the pipeline
	assign credit = int'(count) < COMMIT_DEPTH - lane_pkg::PIPE_DEPTH;

endmodule

`default_nettype wire

//--- rtl/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
	input wire logic clock,
	input wire logic reset,
	input wire lane_pkg::operand_t operand,
	output lane_pkg::result_t result
);

	lane_pkg::data_t src1;
	lane_pkg::data_t src2;
	lane_pkg::data_t alu;
	logic fwd1;
	logic fwd2;

	////////////////////
	// Forwarding from write-back

	assign fwd1 = result.valid && result.dst == operand.dec.src1;
	assign fwd2 = result.valid && result.dst == operand.dec.src2;
	assign src1 = fwd1 ? result.data : operand.src1_data;
	assign src2 = fwd2 ? result.data : operand.src2_data;

	always_comb begin
		case (operand.dec.opcode)
			lane_pkg::ADD:  alu = src1 + src2;
			lane_pkg::SUB:  alu = src1 - src2;
			lane_pkg::AND:  alu = src1 & src2;
			lane_pkg::OR:   alu = src1 | src2;
			lane_pkg::XOR:  alu = src1 ^ src2;
			lane_pkg::MOVI: alu = operand.dec.imm;
			default:        alu = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		result.valid <= operand.dec.valid;
		result.issue_no <= operand.dec.issue_no;
		result.dst <= operand.dec.dst;
		result.data <= alu;
		if (reset) begin
			result.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/operand_read.sv
`timescale 1ns/1ps
`default_nettype none

module operand_read (
	input wire logic clock,
	input wire logic reset,
	input wire lane_pkg::decoded_t decoded,
	input wire lane_pkg::result_t wb,
	output lane_pkg::operand_t operand
);

	lane_pkg::decoded_t dec_q;
	lane_pkg::data_t even_a;
	lane_pkg::data_t even_b;
	lane_pkg::data_t odd_a;
	lane_pkg::data_t odd_b;
	logic even_we;
	logic odd_we;

	assign even_we = wb.valid & ~wb.dst[0];
	assign odd_we = wb.valid & wb.dst[0];

	////////////////////
	// Banks, port a for src1, port b for src2

	reg_bank even_bank (
		.clock(clock),
		.reset(reset),
		.read_idx_a(decoded.src1[$bits(lane_pkg::phys_idx_t)-1:1]),
		.read_idx_b(decoded.src2[$bits(lane_pkg::phys_idx_t)-1:1]),
		.read_data_a(even_a),
		.read_data_b(even_b),
		.write_en(even_we),
		.write_idx(wb.dst[$bits(lane_pkg::phys_idx_t)-1:1]),
		.write_data(wb.data)
	);

	reg_bank odd_bank (
		.clock(clock),
		.reset(reset),
		.read_idx_a(decoded.src1[$bits(lane_pkg::phys_idx_t)-1:1]),
		.read_idx_b(decoded.src2[$bits(lane_pkg::phys_idx_t)-1:1]),
		.read_data_a(odd_a),
		.read_data_b(odd_b),
		.write_en(odd_we),
		.write_idx(wb.dst[$bits(lane_pkg::phys_idx_t)-1:1]),
		.write_data(wb.data)
	);

	// Fields follow the registered bank reads
	always_ff @(posedge clock) begin
		dec_q <= decoded;
		if (reset) begin
			dec_q.valid <= 1'b0;
		end
	end

	assign operand.dec = dec_q;
	assign operand.src1_data = dec_q.src1[0] ? odd_a : even_a;
	assign operand.src2_data = dec_q.src2[0] ? odd_b : even_b;

endmodule

`default_nettype wire

//--- rtl/index_stage.sv
`timescale 1ns/1ps
`default_nettype none

module index_stage (
	input wire logic clock,
	input wire logic reset,
	input wire lane_pkg::issue_t issue,
	output lane_pkg::decoded_t decoded
);

	lane_pkg::instr_t instr;
	lane_pkg::decoded_t dec_d;

	assign instr = issue.instr;

	always_comb begin
		dec_d = '0;
		dec_d.valid = issue.valid;
		dec_d.issue_no = issue.issue_no;
		dec_d.opcode = instr.opcode;
		if (instr.opcode == lane_pkg::MOVI) begin
			dec_d.dst = {instr.window, instr.body.im.dst};
			dec_d.imm = {{(lane_pkg::DATA_WIDTH - lane_pkg::IMM_WIDTH)
				{instr.body.im.imm[lane_pkg::IMM_WIDTH-1]}}, instr.body.im.imm};
		end else begin
			// Window number forms the upper index bits
			dec_d.dst = {instr.window, instr.body.rf.dst};
			dec_d.src1 = {instr.window, instr.body.rf.src1};
			dec_d.src2 = {instr.window, instr.body.rf.src2};
		end
	end

	always_ff @(posedge clock) begin
		decoded <= dec_d;
		if (reset) begin
			decoded.valid <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- rtl/cmd_intake.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_intake #(
	parameter int BUFF_DEPTH = 4
) (
	input wire logic clock,
	input wire logic reset,
	input wire lane_pkg::wb_req_t wb_req,
	output lane_pkg::wb_rsp_t wb_rsp,
	input wire logic credit,
	output lane_pkg::issue_t issue
);

	localparam int PTR_W = (BUFF_DEPTH > 1) ? $clog2(BUFF_DEPTH) : 1;
	localparam int CNT_W = $clog2(BUFF_DEPTH + 1);

	typedef struct packed {
		lane_pkg::issue_no_t issue_no;
		lane_pkg::instr_t instr;
	} entry_t;

	entry_t buff [BUFF_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	lane_pkg::issue_no_t next_no;	// Number of the next accepted write
	lane_pkg::data_t rd_data;
	logic ack;
	logic req;
	logic full;
	logic empty;
	logic push;
	logic pop;

	assign full = count == CNT_W'(BUFF_DEPTH);
	assign empty = count == '0;
	assign req = wb_req.cyc & wb_req.stb & ~ack;	// New strobe
	assign push = req & wb_req.we & ~full;
	assign pop = ~empty & credit;

	////////////////////
	// Wishbone slave

	always_ff @(posedge clock) begin
		if (reset) begin
			ack <= 1'b0;
		end else begin
			ack <= push | (req & ~wb_req.we);	// Writes wait for room
		end
	end

	always_ff @(posedge clock) begin
		if (req & ~wb_req.we) begin
			rd_data <= lane_pkg::data_t'(next_no);
		end
	end

	assign wb_rsp.ack = ack;
	assign wb_rsp.dat = rd_data;

	////////////////////
	// Ring buffer

	always_ff @(posedge clock) begin
		if (push) begin
			buff[wr_ptr] <= '{issue_no: next_no, instr: lane_pkg::instr_t'(wb_req.dat)};
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			next_no <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(BUFF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
				next_no <= next_no + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(BUFF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	// Head goes straight to the index stage
	assign issue.valid = pop;
	assign issue.issue_no = buff[rd_ptr].issue_no;
	assign issue.instr = buff[rd_ptr].instr;

endmodule

`default_nettype wire

//--- rtl/reg_bank.sv
`timescale 1ns/1ps
`default_nettype none

module reg_bank (
	input wire logic clock,
	input wire logic reset,
	input wire lane_pkg::bank_idx_t read_idx_a,
	input wire lane_pkg::bank_idx_t read_idx_b,
	output lane_pkg::data_t read_data_a,
	output lane_pkg::data_t read_data_b,
	input wire logic write_en,
	input wire lane_pkg::bank_idx_t write_idx,
	input wire lane_pkg::data_t write_data
);

	localparam int NUM_REGS = 2 ** $bits(lane_pkg::bank_idx_t);

	lane_pkg::data_t regs [NUM_REGS];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			read_data_a <= '0;
			read_data_b <= '0;
		end else begin
			if (write_en) begin
				regs[write_idx] <= write_data;
			end
			// Write-through on a same-cycle hit
			read_data_a <= (write_en && write_idx == read_idx_a) ? write_data : regs[read_idx_a];
			read_data_b <= (write_en && write_idx == read_idx_b) ? write_data : regs[read_idx_b];
		end
	end

endmodule

`default_nettype wire

//--- rtl/lane_pkg.sv
`default_nettype none

package lane_pkg;

	localparam int DATA_WIDTH = 32;
	localparam int WINDOW_SIZE = 16;
	localparam int NUM_WINDOWS = 4;
	localparam int IMM_WIDTH = 16;
	localparam int PIPE_DEPTH = 3;	// Index, read, execute

	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [$clog2(WINDOW_SIZE)-1:0] reg_no_t;
	typedef logic [$clog2(NUM_WINDOWS)-1:0] window_t;
	typedef logic [$bits(window_t)+$bits(reg_no_t)-1:0] phys_idx_t;	// Bit 0 picks the bank
	typedef logic [$bits(phys_idx_t)-2:0] bank_idx_t;
	typedef logic [7:0] issue_no_t;

	typedef enum logic [2:0] {
		ADD  = 3'd0,
		SUB  = 3'd1,
		AND  = 3'd2,
		OR   = 3'd3,
		XOR  = 3'd4,
		MOVI = 3'd5
	} opcode_t;

	////////////////////
	// Instruction word

	typedef struct packed {
		reg_no_t dst;
		reg_no_t src1;
		reg_no_t src2;
		logic [14:0] pad;
	} reg_form_t;

	typedef struct packed {
		reg_no_t dst;
		logic [IMM_WIDTH-1:0] imm;
		logic [6:0] pad;
	} imm_form_t;

	typedef union packed {
		reg_form_t rf;
		imm_form_t im;
	} instr_body_u;

	typedef struct packed {
		opcode_t opcode;
		window_t window;
		instr_body_u body;
	} instr_t;

	////////////////////
	// Bus and pipeline

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		data_t dat;
	} wb_req_t;

	typedef struct packed {
		logic ack;
		data_t dat;
	} wb_rsp_t;

	typedef struct packed {
		logic valid;
		issue_no_t issue_no;
		instr_t instr;
	} issue_t;

	typedef struct packed {
		logic valid;
		issue_no_t issue_no;
		opcode_t opcode;
		phys_idx_t dst;
		phys_idx_t src1;
		phys_idx_t src2;
		data_t imm;	// Already sign-extended
	} decoded_t;

	typedef struct packed {
		decoded_t dec;
		data_t src1_data;
		data_t src2_data;
	} operand_t;

	typedef struct packed {
		logic valid;
		issue_no_t issue_no;
		phys_idx_t dst;
		data_t data;
	} result_t;

endpackage

`default_nettype wire
